/* verilog/soc_bus_pkg.sv */
package soc_bus_pkg;

	//////////////////////
	// Bus widths
	//////////////////////

	// Four address bits cover the whole register window
	localparam int AXIL_ADDR_W = 4;
	localparam int AXIL_DATA_W = 32;

	// AXI4-Lite response codes
	// EXOKAY and DECERR are not used
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axil_resp_e;

	//////////////////////
	// Register map
	//////////////////////

	// Write sends a byte, read gives zero
	localparam logic [AXIL_ADDR_W-1:0] REG_UART_TX  = 4'h0;
	// Read only
	localparam logic [AXIL_ADDR_W-1:0] REG_STATUS   = 4'h4;
	// Write starts an exchange, read gives last received byte
	localparam logic [AXIL_ADDR_W-1:0] REG_SPI_DATA = 4'h8;

	// Status word bit positions
	localparam int STAT_UART_BUSY = 0;
	localparam int STAT_SPI_BUSY  = 1;
	// Sticky until a status read
	localparam int STAT_SPI_DONE  = 2;

endpackage

/* verilog/soc_periph_pkg.sv */
package soc_periph_pkg;

	//////////////////////
	// UART timing
	//////////////////////

	// Fixed divider with no run-time baud setting
	localparam int UART_CLKS_PER_BIT = 16;
	localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);

	// One 8N1 frame
	typedef enum logic [1:0] {
		UART_IDLE  = 2'd0,
		UART_START = 2'd1,
		UART_DATA  = 2'd2,
		UART_STOP  = 2'd3
	} uart_state_e;

	//////////////////////
	// SPI timing
	//////////////////////

	// Clocks per SCK half period
	localparam int SPI_HALF_CLKS = 4;
	localparam int SPI_CNT_W     = $clog2(SPI_HALF_CLKS);

	// Select low, eight SCK periods, then the hold before deselect
	typedef enum logic [1:0] {
		SPI_IDLE     = 2'd0,
		SPI_SELECT   = 2'd1,
		SPI_SHIFT    = 2'd2,
		SPI_DESELECT = 2'd3
	} spi_state_e;

endpackage

/* verilog/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx (
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  logic       start_i,
	input  logic [7:0] byte_i,
	output logic       busy_o,
	output logic       tx_o
);

	import soc_periph_pkg::*;

	uart_state_e           state_q;
	logic [UART_CNT_W-1:0] tick_q;
	logic [2:0]            bit_q;
	logic [7:0]            shift_q;
	logic                  bit_end;

	// Last clock of the current bit cell
	assign bit_end = (tick_q == UART_CNT_W'(UART_CLKS_PER_BIT - 1));
	// Busy from the cycle after start until the stop bit ends
	assign busy_o  = (state_q != UART_IDLE);

	// Bit-time counter restarts at each cell boundary
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			tick_q <= '0;
		end else if (state_q == UART_IDLE || bit_end) begin
			tick_q <= '0;
		end else begin
			tick_q <= tick_q + 1'b1;
		end
	end

	// Shift register sends the LSB first
	always_ff @(posedge clk_i) begin
		if (state_q == UART_IDLE && start_i) begin
			shift_q <= byte_i;
		end else if (bit_end) begin
			shift_q <= {1'b0, shift_q[7:1]};
		end
	end

	//////////////////////
	// Frame FSM
	//////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= UART_IDLE;
			bit_q   <= '0;
			tx_o    <= 1'b1;
		end else begin
			case (state_q)
				UART_IDLE: begin
					// Line idles high
					tx_o <= 1'b1;
					if (start_i) begin
						state_q <= UART_START;
						tx_o    <= 1'b0;
					end
				end
				UART_START: begin
					if (bit_end) begin
						state_q <= UART_DATA;
						tx_o    <= shift_q[0];
						bit_q   <= '0;
					end
				end
				UART_DATA: begin
					if (bit_end) begin
						if (bit_q == 3'd7) begin
							// Stop bit
							state_q <= UART_STOP;
							tx_o    <= 1'b1;
						end else begin
							tx_o  <= shift_q[0];
							bit_q <= bit_q + 1'b1;
						end
					end
				end
				UART_STOP: begin
					if (bit_end) begin
						state_q <= UART_IDLE;
					end
				end
				default: state_q <= UART_IDLE;
			endcase
		end
	end

endmodule

/* verilog/spi_master.sv */
`timescale 1ns/100ps

module spi_master (
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  logic       start_i,
	input  logic [7:0] byte_i,
	output logic       busy_o,
	output logic       done_o,
	output logic [7:0] rx_byte_o,
	output logic       sck_o,
	output logic       mosi_o,
	input  logic       miso_i,
	output logic       ss_n_o
);

	import soc_periph_pkg::*;

	spi_state_e           state_q;
	logic [SPI_CNT_W-1:0] half_q;
	logic [2:0]           bit_q;
	logic [7:0]           shift_q;
	logic                 half_end;
	logic                 sck_rise;
	logic                 sck_fall;

	assign half_end = (half_q == SPI_CNT_W'(SPI_HALF_CLKS - 1));
	// First rise comes out of SELECT, the rest from the low half of SHIFT
	assign sck_rise = half_end && (state_q == SPI_SELECT || (state_q == SPI_SHIFT && !sck_o));
	assign sck_fall = half_end && state_q == SPI_SHIFT && sck_o;
	assign busy_o   = (state_q != SPI_IDLE);

	// Transmit bits leave at the top, receive bits enter at the bottom,
	// so after eight rises the register holds the slave's byte
	assign rx_byte_o = shift_q;

	// Half-period counter
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			half_q <= '0;
		end else if (state_q == SPI_IDLE || half_end) begin
			half_q <= '0;
		end else begin
			half_q <= half_q + 1'b1;
		end
	end

	// Load on start, sample MISO on each rising SCK
	always_ff @(posedge clk_i) begin
		if (state_q == SPI_IDLE && start_i) begin
			shift_q <= byte_i;
		end else if (sck_rise) begin
			shift_q <= {shift_q[6:0], miso_i};
		end
	end

	//////////////////////
	// Exchange FSM
	//////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= SPI_IDLE;
			bit_q   <= '0;
			sck_o   <= 1'b0;
			mosi_o  <= 1'b0;
			ss_n_o  <= 1'b1;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state_q)
				SPI_IDLE: begin
					if (start_i) begin
						// MSB valid on the select edge
						state_q <= SPI_SELECT;
						ss_n_o  <= 1'b0;
						mosi_o  <= byte_i[7];
						bit_q   <= '0;
					end
				end
				SPI_SELECT: begin
					// Low half of the first period
					if (half_end) begin
						state_q <= SPI_SHIFT;
						sck_o   <= 1'b1;
					end
				end
				SPI_SHIFT: begin
					if (sck_rise) begin
						sck_o <= 1'b1;
					end else if (sck_fall) begin
						sck_o <= 1'b0;
						if (bit_q == 3'd7) begin
							state_q <= SPI_DESELECT;
						end else begin
							// Next bit out on the falling edge
							mosi_o <= shift_q[7];
							bit_q  <= bit_q + 1'b1;
						end
					end
				end
				SPI_DESELECT: begin
					// Hold select one half period past the last fall
					if (half_end) begin
						state_q <= SPI_IDLE;
						ss_n_o  <= 1'b1;
						done_o  <= 1'b1;
					end
				end
				default: state_q <= SPI_IDLE;
			endcase
		end
	end

endmodule

/* verilog/axil_periph_regs.sv */
`timescale 1ns/100ps

module axil_periph_regs (
	input  logic                               clk_i,
	input  logic                               rst_n_i,
	input  logic [soc_bus_pkg::AXIL_ADDR_W-1:0] awaddr_i,
	input  logic                               awvalid_i,
	output logic                               awready_o,
	input  logic [soc_bus_pkg::AXIL_DATA_W-1:0] wdata_i,
	input  logic                               wvalid_i,
	output logic                               wready_o,
	output logic [1:0]                         bresp_o,
	output logic                               bvalid_o,
	input  logic                               bready_i,
	input  logic [soc_bus_pkg::AXIL_ADDR_W-1:0] araddr_i,
	input  logic                               arvalid_i,
	output logic                               arready_o,
	output logic [soc_bus_pkg::AXIL_DATA_W-1:0] rdata_o,
	output logic [1:0]                         rresp_o,
	output logic                               rvalid_o,
	input  logic                               rready_i,
	output logic                               uart_start_o,
	output logic [7:0]                         uart_byte_o,
	input  logic                               uart_busy_i,
	output logic                               spi_start_o,
	output logic [7:0]                         spi_byte_o,
	input  logic                               spi_busy_i,
	input  logic                               spi_done_i,
	input  logic [7:0]                         spi_rx_byte_i
);

	import soc_bus_pkg::*;

	logic                   wr_hs;
	logic                   rd_hs;
	logic                   uart_sel;
	logic                   spi_sel;
	logic                   done_q;
	logic [7:0]             rx_q;
	logic [7:0]             rx_byte;
	logic [AXIL_DATA_W-1:0] rd_word;
	axil_resp_e             rd_resp;
	axil_resp_e             bresp_q;
	axil_resp_e             rresp_q;

	//////////////////////
	// Write channel
	//////////////////////

	// Address and data accepted together, blocked by a pending response
	assign wr_hs     = awvalid_i & wvalid_i & ~bvalid_o;
	assign awready_o = wr_hs;
	assign wready_o  = wr_hs;

	assign uart_sel = (awaddr_i == REG_UART_TX);
	assign spi_sel  = (awaddr_i == REG_SPI_DATA);

	// Engines only see a start when idle
	assign uart_start_o = wr_hs & uart_sel & ~uart_busy_i;
	assign spi_start_o  = wr_hs & spi_sel & ~spi_busy_i;
	// Byte strobes ignored
	assign uart_byte_o  = wdata_i[7:0];
	assign spi_byte_o   = wdata_i[7:0];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			bvalid_o <= 1'b0;
		end else if (wr_hs) begin
			bvalid_o <= 1'b1;
		end else if (bready_i) begin
			bvalid_o <= 1'b0;
		end
	end

	// Busy target, status or unmapped address gives SLVERR
	always_ff @(posedge clk_i) begin
		if (wr_hs) begin
			bresp_q <= (uart_start_o | spi_start_o) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	assign bresp_o = bresp_q;

	//////////////////////
	// Read channel
	//////////////////////

	assign rd_hs     = arvalid_i & ~rvalid_o;
	assign arready_o = rd_hs;

	// A done pulse in this cycle already counts
	assign rx_byte = spi_done_i ? spi_rx_byte_i : rx_q;

	always_comb begin
		rd_word = '0;
		rd_resp = RESP_OKAY;
		case (araddr_i)
			REG_UART_TX: rd_resp = RESP_OKAY;
			REG_STATUS: begin
				rd_word[STAT_UART_BUSY] = uart_busy_i;
				rd_word[STAT_SPI_BUSY]  = spi_busy_i;
				rd_word[STAT_SPI_DONE]  = done_q | spi_done_i;
			end
			REG_SPI_DATA: rd_word[7:0] = rx_byte;
			default: rd_resp = RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rvalid_o <= 1'b0;
		end else if (rd_hs) begin
			rvalid_o <= 1'b1;
		end else if (rready_i) begin
			rvalid_o <= 1'b0;
		end
	end

	// Held until rready
	always_ff @(posedge clk_i) begin
		if (rd_hs) begin
			rdata_o <= rd_word;
			rresp_q <= rd_resp;
		end
	end

	assign rresp_o = rresp_q;

	//////////////////////
	// SPI result
	//////////////////////

	// Set wins over clear when both land in one cycle
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			done_q <= 1'b0;
			rx_q   <= '0;
		end else begin
			if (spi_done_i) begin
				done_q <= 1'b1;
				rx_q   <= spi_rx_byte_i;
			end else if (rd_hs && araddr_i == REG_STATUS) begin
				done_q <= 1'b0;
			end
		end
	end

endmodule

/* verilog/soc_periph_top.sv */
`timescale 1ns/100ps

module soc_periph_top (
	input  logic                               clk_i,
	input  logic                               rst_n_i,
	input  logic [soc_bus_pkg::AXIL_ADDR_W-1:0] awaddr_i,
	input  logic                               awvalid_i,
	output logic                               awready_o,
	input  logic [soc_bus_pkg::AXIL_DATA_W-1:0] wdata_i,
	input  logic                               wvalid_i,
	output logic                               wready_o,
	output logic [1:0]                         bresp_o,
	output logic                               bvalid_o,
	input  logic                               bready_i,
	input  logic [soc_bus_pkg::AXIL_ADDR_W-1:0] araddr_i,
	input  logic                               arvalid_i,
	output logic                               arready_o,
	output logic [soc_bus_pkg::AXIL_DATA_W-1:0] rdata_o,
	output logic [1:0]                         rresp_o,
	output logic                               rvalid_o,
	input  logic                               rready_i,
	output logic                               uart_tx_o,
	output logic                               spi_sck_o,
	output logic                               spi_mosi_o,
	input  logic                               spi_miso_i,
	output logic                               spi_ss_n_o
);

	// Register block to engines
	logic       uart_start;
	logic [7:0] uart_byte;
	logic       uart_busy;
	logic       spi_start;
	logic [7:0] spi_byte;
	logic       spi_busy;
	logic       spi_done;
	logic [7:0] spi_rx_byte;

	// AXI4-Lite ports share names with the top
	axil_periph_regs u_regs (
		.uart_start_o  (uart_start),
		.uart_byte_o   (uart_byte),
		.uart_busy_i   (uart_busy),
		.spi_start_o   (spi_start),
		.spi_byte_o    (spi_byte),
		.spi_busy_i    (spi_busy),
		.spi_done_i    (spi_done),
		.spi_rx_byte_i (spi_rx_byte),
		.*
	);

	// Console transmitter
	uart_tx u_uart (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.start_i (uart_start),
		.byte_i  (uart_byte),
		.busy_o  (uart_busy),
		.tx_o    (uart_tx_o)
	);

	// Flash style SPI master
	spi_master u_spi (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.start_i   (spi_start),
		.byte_i    (spi_byte),
		.busy_o    (spi_busy),
		.done_o    (spi_done),
		.rx_byte_o (spi_rx_byte),
		.sck_o     (spi_sck_o),
		.mosi_o    (spi_mosi_o),
		.miso_i    (spi_miso_i),
		.ss_n_o    (spi_ss_n_o)
	);

endmodule

/* testbench/soc_periph_sva.sv */
`timescale 1ns/100ps

module soc_periph_sva (
	input logic                               clk_i,
	input logic                               rst_n_i,
	input logic                               bvalid_i,
	input logic                               bready_i,
	input logic [1:0]                         bresp_i,
	input logic                               rvalid_i,
	input logic                               rready_i,
	input logic [soc_bus_pkg::AXIL_DATA_W-1:0] rdata_i,
	input logic                               uart_start_i,
	input logic                               uart_busy_i,
	input logic                               spi_start_i,
	input logic                               spi_busy_i
);

	// Count of failed assertions
	int unsigned fail_count = 0;

	////////////////////
	// Bus channels
	////////////////////

	// Write response held until bready
	a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
		else begin
			$error("write response dropped or changed before bready");
			fail_count++;
		end

	// Read response held until rready
	a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
		else begin
			$error("read response dropped or changed before rready");
			fail_count++;
		end

	////////////////////
	// Engine starts
	////////////////////

	// An idle engine takes the start and turns busy one cycle later
	a_uart_start: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		uart_start_i |-> !uart_busy_i ##1 uart_busy_i)
		else begin
			$error("UART start met a busy engine or busy did not rise after it");
			fail_count++;
		end

	a_spi_start: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		spi_start_i |-> !spi_busy_i ##1 spi_busy_i)
		else begin
			$error("SPI start met a busy engine or busy did not rise after it");
			fail_count++;
		end

endmodule

bind axil_periph_regs soc_periph_sva u_sva (
	.clk_i        (clk_i),
	.rst_n_i      (rst_n_i),
	.bvalid_i     (bvalid_o),
	.bready_i     (bready_i),
	.bresp_i      (bresp_o),
	.rvalid_i     (rvalid_o),
	.rready_i     (rready_i),
	.rdata_i      (rdata_o),
	.uart_start_i (uart_start_o),
	.uart_busy_i  (uart_busy_i),
	.spi_start_i  (spi_start_o),
	.spi_busy_i   (spi_busy_i)
);

/* testbench/soc_periph_tb.sv */
`timescale 1ns/100ps

module soc_periph_tb;

	import soc_bus_pkg::*;
	import soc_periph_pkg::*;

	localparam int VEC_MAX  = 64;
	localparam int VEC_COLS = 5;
	// Clocks from the select edge to the deselect edge
	localparam int SPI_XFER_CLKS = 17 * SPI_HALF_CLKS;

	logic                   clk = 1'b0;
	logic                   rst_n;
	logic [AXIL_ADDR_W-1:0] awaddr;
	logic                   awvalid;
	logic                   awready;
	logic [AXIL_DATA_W-1:0] wdata;
	logic                   wvalid;
	logic                   wready;
	logic [1:0]             bresp;
	logic                   bvalid;
	logic                   bready;
	logic [AXIL_ADDR_W-1:0] araddr;
	logic                   arvalid;
	logic                   arready;
	logic [AXIL_DATA_W-1:0] rdata;
	logic [1:0]             rresp;
	logic                   rvalid;
	logic                   rready;
	logic                   uart_tx;
	logic                   spi_sck;
	logic                   spi_mosi;
	logic                   spi_miso = 1'b0;
	logic                   spi_ss_n;

	// Five words per vector
	logic [31:0] vec_mem [0:VEC_COLS*VEC_MAX-1];
	int          errors = 0;
	int          stall = 0;
	int          limit;
	// Decoded UART bytes, SPI bytes seen on MOSI and SCK rise counts
	logic [7:0]  uart_q[$];
	logic [7:0]  spi_rx_q[$];
	int          spi_rise_q[$];
	// SPI slave model state
	logic [7:0]  reply_byte = 8'h00;
	logic        ss_prev;
	logic        sck_prev;
	logic [7:0]  slave_rx;
	int          slave_rises;
	int          slave_bit;

	always #5 clk = ~clk;

	soc_periph_top u_soc_periph_top (
		.clk_i      (clk),
		.rst_n_i    (rst_n),
		.awaddr_i   (awaddr),
		.awvalid_i  (awvalid),
		.awready_o  (awready),
		.wdata_i    (wdata),
		.wvalid_i   (wvalid),
		.wready_o   (wready),
		.bresp_o    (bresp),
		.bvalid_o   (bvalid),
		.bready_i   (bready),
		.araddr_i   (araddr),
		.arvalid_i  (arvalid),
		.arready_o  (arready),
		.rdata_o    (rdata),
		.rresp_o    (rresp),
		.rvalid_o   (rvalid),
		.rready_i   (rready),
		.uart_tx_o  (uart_tx),
		.spi_sck_o  (spi_sck),
		.spi_mosi_o (spi_mosi),
		.spi_miso_i (spi_miso),
		.spi_ss_n_o (spi_ss_n)
	);

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		errors++;
		$display("error %s: expected %h, actual %h", name, exp, act);
	endtask

	task automatic note_failure(input string what);
		errors++;
		$display("%s", what);
	endtask

	////////////////////
	// Bus tasks
	////////////////////

	// Response held back for stall cycles before bready
	task automatic bus_write(input logic [AXIL_ADDR_W-1:0] addr,
			input logic [AXIL_DATA_W-1:0] data, output logic [1:0] resp);
		logic [1:0] held;
		@(negedge clk);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		// Readies looked at in the low half of the clock
		#1;
		while (!(awready && wready)) begin
			@(negedge clk);
			#1;
		end
		// bvalid is due one cycle after the handshake edge
		@(negedge clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		if (bvalid !== 1'b1) begin
			note_failure("write response did not follow the write handshake");
		end
		held = bresp;
		repeat (stall) begin
			@(negedge clk);
			if (!bvalid || bresp !== held) begin
				note_failure("write response dropped or changed while bready was low");
			end
		end
		resp   = bresp;
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
		stall  = 0;
		if (bvalid) begin
			note_failure("write response still valid after bready");
		end
	endtask

	task automatic bus_read(input logic [AXIL_ADDR_W-1:0] addr, output logic [1:0] resp,
			output logic [AXIL_DATA_W-1:0] data);
		logic [1:0]             held_resp;
		logic [AXIL_DATA_W-1:0] held_data;
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		// arready looked at in the low half of the clock
		#1;
		while (!arready) begin
			@(negedge clk);
			#1;
		end
		// rvalid is due one cycle after the handshake edge
		@(negedge clk);
		arvalid = 1'b0;
		if (rvalid !== 1'b1) begin
			note_failure("read response did not follow the read handshake");
		end
		held_resp = rresp;
		held_data = rdata;
		repeat (stall) begin
			@(negedge clk);
			if (!rvalid || rresp !== held_resp || rdata !== held_data) begin
				note_failure("read response dropped or changed while rready was low");
			end
		end
		resp   = rresp;
		data   = rdata;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
		stall  = 0;
		if (rvalid) begin
			note_failure("read response still valid after rready");
		end
	endtask

	////////////////////
	// Line models
	////////////////////

	// UART decoder samples mid cell and pushes once the stop bit is over
	initial begin : uart_decoder
		logic [7:0] rx;
		@(posedge rst_n);
		forever begin
			@(negedge uart_tx);
			repeat (UART_CLKS_PER_BIT / 2) @(negedge clk);
			if (uart_tx !== 1'b0) begin
				note_failure("UART start bit ended early");
			end
			for (int b = 0; b < 8; b++) begin
				repeat (UART_CLKS_PER_BIT) @(negedge clk);
				rx[b] = uart_tx;
			end
			repeat (UART_CLKS_PER_BIT) @(negedge clk);
			if (uart_tx !== 1'b1) begin
				note_failure("UART stop bit was not high");
			end
			repeat (UART_CLKS_PER_BIT / 2 + 1) @(negedge clk);
			uart_q.push_back(rx);
		end
	end

	// SPI slave model sees each edge one falling clock later
	always @(negedge clk) begin
		if (!rst_n) begin
			ss_prev  = 1'b1;
			sck_prev = 1'b0;
		end else begin
			if (ss_prev && !spi_ss_n) begin
				// Reply MSB goes out on the select edge
				spi_miso    = reply_byte[7];
				slave_bit   = 6;
				slave_rises = 0;
				slave_rx    = 8'h00;
			end else if (!spi_ss_n && !sck_prev && spi_sck) begin
				slave_rx    = {slave_rx[6:0], spi_mosi};
				slave_rises = slave_rises + 1;
			end else if (!spi_ss_n && sck_prev && !spi_sck) begin
				if (slave_bit >= 0) begin
					spi_miso = reply_byte[slave_bit];
				end
				slave_bit = slave_bit - 1;
			end else if (!ss_prev && spi_ss_n) begin
				spi_rx_q.push_back(slave_rx);
				spi_rise_q.push_back(slave_rises);
			end
			ss_prev  = spi_ss_n;
			sck_prev = spi_sck;
		end
	end

	////////////////////
	// Vector run
	////////////////////

	initial begin : main
		logic [31:0]            op;
		logic [31:0]            addr;
		logic [31:0]            data;
		logic [31:0]            exp_resp;
		logic [31:0]            exp_data;
		logic [1:0]             resp;
		logic [AXIL_DATA_W-1:0] rd;
		logic [7:0]             got;
		int                     rises;
		int                     sum;
		int                     idx;
		bit                     running;
		string                  name;
		rst_n    = 1'b0;
		awaddr   = '0;
		awvalid  = 1'b0;
		wdata    = '0;
		wvalid   = 1'b0;
		bready   = 1'b0;
		araddr   = '0;
		arvalid  = 1'b0;
		rready   = 1'b0;
		$readmemh("testbench/soc_periph_vectors.txt", vec_mem);
		// Watchdog budget
		sum = 0;
		for (int i = 0; i < VEC_MAX; i++) begin
			if (vec_mem[VEC_COLS*i] === 32'h0 && vec_mem[VEC_COLS*i+1] === REG_UART_TX) begin
				sum = sum + 10 * UART_CLKS_PER_BIT;
			end
			if (vec_mem[VEC_COLS*i] === 32'h0 && vec_mem[VEC_COLS*i+1] === REG_SPI_DATA) begin
				sum = sum + SPI_XFER_CLKS;
			end
			if (vec_mem[VEC_COLS*i] === 32'h5) begin
				sum = sum + vec_mem[VEC_COLS*i+2];
			end
		end
		limit = 2 * sum + 1000;
		fork
			begin
				repeat (limit) @(posedge clk);
				$display("watchdog expired after %0d cycles, run did not finish", limit);
				$display("Errors found");
				$finish;
			end
		join_none
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		// Idle pins out of reset
		if (uart_tx !== 1'b1) begin
			report_mismatch("reset uart_tx_o", 1, uart_tx);
		end
		if (spi_ss_n !== 1'b1) begin
			report_mismatch("reset spi_ss_n_o", 1, spi_ss_n);
		end
		if (spi_sck !== 1'b0) begin
			report_mismatch("reset spi_sck_o", 0, spi_sck);
		end
		idx     = 0;
		running = 1'b1;
		while (running) begin
			op       = vec_mem[VEC_COLS*idx];
			addr     = vec_mem[VEC_COLS*idx+1];
			data     = vec_mem[VEC_COLS*idx+2];
			exp_resp = vec_mem[VEC_COLS*idx+3];
			exp_data = vec_mem[VEC_COLS*idx+4];
			name     = $sformatf("vector %0d", idx);
			case (op)
				32'h0: begin
					bus_write(addr[AXIL_ADDR_W-1:0], data, resp);
					if (resp !== exp_resp[1:0]) begin
						report_mismatch({name, " bresp"}, exp_resp, resp);
					end
				end
				32'h1: begin
					bus_read(addr[AXIL_ADDR_W-1:0], resp, rd);
					if (resp !== exp_resp[1:0]) begin
						report_mismatch({name, " rresp"}, exp_resp, resp);
					end
					if (rd !== exp_data) begin
						report_mismatch({name, " rdata"}, exp_data, rd);
					end
				end
				32'h2: begin
					while (uart_q.size() == 0) begin
						@(negedge clk);
					end
					got = uart_q.pop_front();
					if (got !== exp_data[7:0]) begin
						report_mismatch({name, " uart byte"}, exp_data, got);
					end
				end
				32'h3: reply_byte = data[7:0];
				32'h4: begin
					while (spi_rx_q.size() == 0) begin
						@(negedge clk);
					end
					got   = spi_rx_q.pop_front();
					rises = spi_rise_q.pop_front();
					if (got !== exp_data[7:0]) begin
						report_mismatch({name, " mosi byte"}, exp_data, got);
					end
					if (rises != 8) begin
						report_mismatch({name, " sck rises"}, 8, rises);
					end
				end
				32'h5: stall = data;
				32'hf: running = 1'b0;
				default: begin
					note_failure($sformatf("%s has no valid operation code", name));
					running = 1'b0;
				end
			endcase
			idx++;
		end
		// Room for a stray frame to show up
		repeat (10 * UART_CLKS_PER_BIT) @(negedge clk);
		if (uart_q.size() != 0) begin
			note_failure("UART sent a frame that no vector expected");
		end
		if (spi_rx_q.size() != 0) begin
			note_failure("SPI ran an exchange that no vector expected");
		end
		$display("errors %0d, assertion failures %0d", errors,
			u_soc_periph_top.u_regs.u_sva.fail_count);
		if (errors == 0 && u_soc_periph_top.u_regs.u_sva.fail_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* soc_periph.f */
verilog/soc_bus_pkg.sv
verilog/soc_periph_pkg.sv
verilog/uart_tx.sv
verilog/spi_master.sv
verilog/axil_periph_regs.sv
verilog/soc_periph_top.sv
testbench/soc_periph_sva.sv
testbench/soc_periph_tb.sv

/* testbench/soc_periph_vectors.txt */
// op addr data resp rdata in hex; op 0 write, 1 read, 2 uart byte, 3 spi reply,
// 4 spi mosi byte, 5 stall next response by data cycles, f end
1 4 00000000 0 00000000
1 8 00000000 0 00000000
0 0 000000a5 0 00000000
1 4 00000000 0 00000001
0 0 0000003c 2 00000000
2 0 00000000 0 000000a5
3 0 0000005a 0 00000000
0 8 000000c3 0 00000000
4 0 00000000 0 000000c3
1 4 00000000 0 00000004
1 8 00000000 0 0000005a
1 4 00000000 0 00000000
3 0 00000096 0 00000000
0 0 0000005c 0 00000000
0 8 0000003e 0 00000000
4 0 00000000 0 0000003e
2 0 00000000 0 0000005c
1 8 00000000 0 00000096
1 4 00000000 0 00000004
1 c 00000000 2 00000000
0 c 12345678 2 00000000
0 4 00000001 2 00000000
5 0 00000004 0 00000000
1 2 00000000 2 00000000
5 0 00000003 0 00000000
1 8 00000000 0 00000096
5 0 00000005 0 00000000
0 c 000000ff 2 00000000
f 0 00000000 0 00000000
